// File: rtl/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_sll, alu_slt,
        alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and, alu_eq, alu_ne,
        alu_lt, alu_ge, alu_ltu, alu_geu
    } alu_op_t;

    // low two bits of funct3 under funct7_mul
    typedef enum logic [1:0] {
        mk_mul    = 2'b00,
        mk_mulh   = 2'b01,
        mk_mulhsu = 2'b10,
        mk_mulhu  = 2'b11
    } mul_kind_t;

    localparam logic [2:0] br_beq  = 3'b000;
    localparam logic [2:0] br_bne  = 3'b001;
    localparam logic [2:0] br_blt  = 3'b100;
    localparam logic [2:0] br_bge  = 3'b101;
    localparam logic [2:0] br_bltu = 3'b110;
    localparam logic [2:0] br_bgeu = 3'b111;

    localparam logic [6:0] funct7_mul = 7'b0000001;

endpackage

// File: rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    localparam int xlen   = 32;
    localparam int reg_aw = 5;

    // operand source for forwarded registers
    typedef enum logic [1:0] {
        fwd_none     = 2'b00,
        fwd_from_wb  = 2'b01,
        fwd_from_mem = 2'b10
    } fwd_sel_t;

endpackage

// File: rtl/id_ex_latch.sv
`timescale 1ns/100ps

module id_ex_latch
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 issue_valid,
    input  logic                                 stall,
    input  logic                                 squash,
    input  rv32i_isa_pkg::opcode_t               opcode,
    input  logic [2:0]                           funct3,
    input  logic [6:0]                           funct7,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     rs1_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     rs2_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       rs1_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       rs2_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       imm,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       pc,

    output logic                                 ex_valid,
    output rv32i_isa_pkg::opcode_t               ex_opcode,
    output logic [2:0]                           ex_funct3,
    output logic [pipe_ctrl_pkg::reg_aw-1:0]     ex_rs1_s,
    output logic [pipe_ctrl_pkg::reg_aw-1:0]     ex_rs2_s,
    output logic [pipe_ctrl_pkg::reg_aw-1:0]     ex_rd_s,
    output logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs1_v,
    output logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs2_v,
    output logic [pipe_ctrl_pkg::xlen-1:0]       ex_imm,
    output logic [pipe_ctrl_pkg::xlen-1:0]       ex_pc,
    output rv32i_isa_pkg::alu_op_t               ex_alu_op,
    output logic                                 ex_use_imm,
    output logic                                 ex_is_mul,
    output rv32i_isa_pkg::mul_kind_t             ex_mul_kind,
    output logic                                 ex_regf_we,
    output logic                                 ex_mem_read,
    output logic                                 ex_mem_write
);

    import rv32i_isa_pkg::*;

    alu_op_t dec_alu_op;
    logic    take;

    // a redirect in ex kills whatever issues at the same edge
    assign take = issue_valid && !squash;

    always_comb
    begin
        dec_alu_op = alu_add;
        case (opcode)
            op_br:
            begin
                case (funct3)
                    br_bne:  dec_alu_op = alu_ne;
                    br_blt:  dec_alu_op = alu_lt;
                    br_bge:  dec_alu_op = alu_ge;
                    br_bltu: dec_alu_op = alu_ltu;
                    br_bgeu: dec_alu_op = alu_geu;
                    default: dec_alu_op = alu_eq;
                endcase
            end
            op_imm, op_reg:
            begin
                case (funct3)
                    3'b000:  dec_alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b001:  dec_alu_op = alu_sll;
                    3'b010:  dec_alu_op = alu_slt;
                    3'b011:  dec_alu_op = alu_sltu;
                    3'b100:  dec_alu_op = alu_xor;
                    3'b101:  dec_alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  dec_alu_op = alu_or;
                    default: dec_alu_op = alu_and;
                endcase
            end
            default: dec_alu_op = alu_add;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex_valid     <= 1'b0;
            ex_opcode    <= op_imm;
            ex_regf_we   <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else if (!stall)
        begin
            ex_valid     <= take;
            ex_opcode    <= opcode;
            ex_regf_we   <= take && !(opcode inside {op_br, op_store});
            ex_mem_read  <= take && (opcode == op_load);
            ex_mem_write <= take && (opcode == op_store);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            ex_funct3   <= funct3;
            ex_rs1_s    <= rs1_s;
            ex_rs2_s    <= rs2_s;
            ex_rd_s     <= rd_s;
            ex_rs1_v    <= rs1_v;
            ex_rs2_v    <= rs2_v;
            ex_imm      <= imm;
            ex_pc       <= pc;
            ex_alu_op   <= dec_alu_op;
            ex_use_imm  <= !(opcode inside {op_reg, op_br});
            ex_is_mul   <= (opcode == op_reg) && (funct7 == funct7_mul);
            ex_mul_kind <= mul_kind_t'(funct3[1:0]);
        end
    end

endmodule

// File: rtl/forwarding_unit.sv
`timescale 1ns/100ps

module forwarding_unit
(
    input  logic [pipe_ctrl_pkg::reg_aw-1:0] rs1_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0] rs2_s,
    input  logic                             mem_we,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0] mem_rd_s,
    input  logic                             wb_we,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0] wb_rd_s,

    output pipe_ctrl_pkg::fwd_sel_t          r1_sel,
    output pipe_ctrl_pkg::fwd_sel_t          r2_sel
);

    import pipe_ctrl_pkg::*;

    // mem is younger than wb so it wins, x0 never forwards
    function automatic fwd_sel_t pick(input logic [reg_aw-1:0] rs);
        fwd_sel_t sel;
        sel = fwd_none;
        if (rs != '0 && mem_we && mem_rd_s == rs)
            sel = fwd_from_mem;
        else if (rs != '0 && wb_we && wb_rd_s == rs)
            sel = fwd_from_wb;
        return sel;
    endfunction

    always_comb
    begin
        r1_sel = pick(rs1_s);
        r2_sel = pick(rs2_s);
    end

endmodule

// File: rtl/pipeline_alu.sv
`timescale 1ns/100ps

module pipeline_alu
(
    input  rv32i_isa_pkg::alu_op_t         alu_op,
    input  logic [pipe_ctrl_pkg::xlen-1:0] a,
    input  logic [pipe_ctrl_pkg::xlen-1:0] b,

    output logic [pipe_ctrl_pkg::xlen-1:0] f
);

    import rv32i_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        f = '0;
        case (alu_op)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $signed(a) >>> shamt;
            alu_xor:  f = a ^ b;
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            // compares land in bit 0
            alu_slt:  f[0] = $signed(a) < $signed(b);
            alu_sltu: f[0] = a < b;
            alu_eq:   f[0] = a == b;
            alu_ne:   f[0] = a != b;
            alu_lt:   f[0] = $signed(a) < $signed(b);
            alu_ge:   f[0] = $signed(a) >= $signed(b);
            alu_ltu:  f[0] = a < b;
            alu_geu:  f[0] = a >= b;
            default:  f = '0;
        endcase
    end

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/100ps

module mul_unit
(
    input  rv32i_isa_pkg::mul_kind_t       mul_kind,
    input  logic [pipe_ctrl_pkg::xlen-1:0] a,
    input  logic [pipe_ctrl_pkg::xlen-1:0] b,

    output logic [pipe_ctrl_pkg::xlen-1:0] p
);

    import rv32i_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic                       a_signed;
    logic                       b_signed;
    logic signed [xlen:0]       a_ext;
    logic signed [xlen:0]       b_ext;
    logic signed [2*xlen+1:0]   prod;

    // low word is the same for any signedness
    assign a_signed = (mul_kind == mk_mulh) || (mul_kind == mk_mulhsu);
    assign b_signed = (mul_kind == mk_mulh);

    assign a_ext = {a_signed & a[xlen-1], a};
    assign b_ext = {b_signed & b[xlen-1], b};
    assign prod  = a_ext * b_ext;

    assign p = (mul_kind == mk_mul) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];

endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage
(
    input  logic                                 ex_valid,
    input  rv32i_isa_pkg::opcode_t               ex_opcode,
    input  logic [2:0]                           ex_funct3,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     ex_rs1_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     ex_rs2_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     ex_rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs1_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ex_rs2_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ex_imm,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ex_pc,
    input  rv32i_isa_pkg::alu_op_t               ex_alu_op,
    input  logic                                 ex_use_imm,
    input  logic                                 ex_is_mul,
    input  rv32i_isa_pkg::mul_kind_t             ex_mul_kind,
    input  logic                                 ex_regf_we,
    input  logic                                 ex_mem_read,
    input  logic                                 ex_mem_write,

    input  logic                                 stall,

    input  logic                                 mem_we,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     mem_rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       mem_value,
    input  logic                                 mem_read,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ld_data,

    input  logic                                 wb_we,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     wb_rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       wb_rd_v,

    output logic                                 nx_valid,
    output logic                                 nx_we,
    output logic [pipe_ctrl_pkg::reg_aw-1:0]     nx_rd_s,
    output logic [pipe_ctrl_pkg::xlen-1:0]       nx_value,
    output logic [pipe_ctrl_pkg::xlen-1:0]       nx_store_data,
    output logic                                 nx_mem_read,
    output logic                                 nx_mem_write,
    output logic [2:0]                           nx_funct3,
    output logic                                 br_en,
    output logic [pipe_ctrl_pkg::xlen-1:0]       redirect_pc
);

    import rv32i_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    fwd_sel_t        r1_sel;
    fwd_sel_t        r2_sel;
    logic [xlen-1:0] mem_fwd;
    logic [xlen-1:0] r1_val;
    logic [xlen-1:0] r2_val;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] f;
    logic [xlen-1:0] mul_p;
    logic [xlen-1:0] jalr_sum;

    // a load in mem hands back its data this same cycle
    assign mem_fwd = mem_read ? ld_data : mem_value;

    always_comb
    begin
        case (r1_sel)
            fwd_from_mem: r1_val = mem_fwd;
            fwd_from_wb:  r1_val = wb_rd_v;
            default:      r1_val = ex_rs1_v;
        endcase
        case (r2_sel)
            fwd_from_mem: r2_val = mem_fwd;
            fwd_from_wb:  r2_val = wb_rd_v;
            default:      r2_val = ex_rs2_v;
        endcase
        case (ex_opcode)
            op_lui:                  a = '0;
            op_auipc, op_jal, op_jalr: a = ex_pc;
            default:                 a = r1_val;
        endcase
    end

    assign b        = ex_use_imm ? ex_imm : r2_val;
    assign jalr_sum = r1_val + ex_imm;

    always_comb
    begin
        br_en       = 1'b0;
        redirect_pc = '0;
        if (ex_valid && !stall)
        begin
            case (ex_opcode)
                op_jalr:
                begin
                    redirect_pc = {jalr_sum[xlen-1:1], 1'b0};
                    br_en       = 1'b1;
                end
                op_jal:
                begin
                    redirect_pc = ex_pc + ex_imm;
                    br_en       = 1'b1;
                end
                op_br:
                begin
                    redirect_pc = ex_pc + ex_imm;
                    br_en       = f[0];
                end
                default: br_en = 1'b0;
            endcase
        end
    end

    assign nx_valid      = ex_valid;
    assign nx_we         = ex_regf_we;
    assign nx_rd_s       = ex_rd_s;
    assign nx_store_data = r2_val;
    assign nx_mem_read   = ex_mem_read;
    assign nx_mem_write  = ex_mem_write;
    assign nx_funct3     = ex_funct3;

    // link value for jumps
    assign nx_value = (ex_opcode inside {op_jal, op_jalr}) ? ex_pc + xlen'(4) :
                      ex_is_mul ? mul_p : f;

    forwarding_unit forwarding_unit_dec_1
    (
        .rs1_s    (ex_rs1_s),
        .rs2_s    (ex_rs2_s),
        .mem_we   (mem_we),
        .mem_rd_s (mem_rd_s),
        .wb_we    (wb_we),
        .wb_rd_s  (wb_rd_s),
        .r1_sel   (r1_sel),
        .r2_sel   (r2_sel)
    );

    pipeline_alu alu_dec_1
    (
        .alu_op (ex_alu_op),
        .a      (a),
        .b      (b),
        .f      (f)
    );

    mul_unit mul_dec_1
    (
        .mul_kind (ex_mul_kind),
        .a        (a),
        .b        (b),
        .p        (mul_p)
    );

endmodule

// File: rtl/ex_mem_latch.sv
`timescale 1ns/100ps

module ex_mem_latch
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             stall,

    input  logic                             nx_valid,
    input  logic                             nx_we,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0] nx_rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   nx_value,
    input  logic [pipe_ctrl_pkg::xlen-1:0]   nx_store_data,
    input  logic                             nx_mem_read,
    input  logic                             nx_mem_write,
    input  logic [2:0]                       nx_funct3,

    output logic                             res_valid,
    output logic                             res_we,
    output logic [pipe_ctrl_pkg::reg_aw-1:0] res_rd_s,
    output logic [pipe_ctrl_pkg::xlen-1:0]   res_value,
    output logic [pipe_ctrl_pkg::xlen-1:0]   res_store_data,
    output logic                             res_mem_read,
    output logic                             res_mem_write,
    output logic [2:0]                       res_funct3
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            res_valid     <= 1'b0;
            res_we        <= 1'b0;
            res_mem_read  <= 1'b0;
            res_mem_write <= 1'b0;
        end
        else if (!stall)
        begin
            res_valid     <= nx_valid;
            res_we        <= nx_we;
            res_mem_read  <= nx_mem_read;
            res_mem_write <= nx_mem_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            res_rd_s       <= nx_rd_s;
            res_value      <= nx_value;
            res_store_data <= nx_store_data;
            res_funct3     <= nx_funct3;
        end
    end

endmodule

// File: rtl/rv32_execute.sv
`timescale 1ns/100ps

module rv32_execute
(
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  logic                                 issue_valid,
    input  rv32i_isa_pkg::opcode_t               opcode,
    input  logic [2:0]                           funct3,
    input  logic [6:0]                           funct7,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     rs1_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     rs2_s,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       rs1_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       rs2_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       imm,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       pc,
    input  logic                                 stall,
    input  logic                                 wb_we,
    input  logic [pipe_ctrl_pkg::reg_aw-1:0]     wb_rd_s,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       wb_rd_v,
    input  logic [pipe_ctrl_pkg::xlen-1:0]       ld_data,

    output logic                                 res_valid,
    output logic                                 res_we,
    output logic [pipe_ctrl_pkg::reg_aw-1:0]     res_rd_s,
    output logic [pipe_ctrl_pkg::xlen-1:0]       res_value,
    output logic [pipe_ctrl_pkg::xlen-1:0]       res_store_data,
    output logic                                 res_mem_read,
    output logic                                 res_mem_write,
    output logic [2:0]                           res_funct3,
    output logic                                 br_en,
    output logic [pipe_ctrl_pkg::xlen-1:0]       redirect_pc
);

    import rv32i_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic              ex_valid;
    opcode_t           ex_opcode;
    logic [2:0]        ex_funct3;
    logic [reg_aw-1:0] ex_rs1_s;
    logic [reg_aw-1:0] ex_rs2_s;
    logic [reg_aw-1:0] ex_rd_s;
    logic [xlen-1:0]   ex_rs1_v;
    logic [xlen-1:0]   ex_rs2_v;
    logic [xlen-1:0]   ex_imm;
    logic [xlen-1:0]   ex_pc;
    alu_op_t           ex_alu_op;
    logic              ex_use_imm;
    logic              ex_is_mul;
    mul_kind_t         ex_mul_kind;
    logic              ex_regf_we;
    logic              ex_mem_read;
    logic              ex_mem_write;

    logic              nx_valid;
    logic              nx_we;
    logic [reg_aw-1:0] nx_rd_s;
    logic [xlen-1:0]   nx_value;
    logic [xlen-1:0]   nx_store_data;
    logic              nx_mem_read;
    logic              nx_mem_write;
    logic [2:0]        nx_funct3;

    id_ex_latch id_ex_latch_dec_1
    (
        .squash (br_en),
        .*
    );

    // registered mem-stage outputs loop back as the forward source
    ex_stage ex_stage_dec_1
    (
        .mem_we    (res_we),
        .mem_rd_s  (res_rd_s),
        .mem_value (res_value),
        .mem_read  (res_mem_read),
        .*
    );

    ex_mem_latch ex_mem_latch_dec_1
    (
        .*
    );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // synchronous reset, low for ten edges
    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: bench/tb_rv32_execute.sv
`timescale 1ns/100ps

module tb_rv32_execute;

    import rv32i_isa_pkg::*;

    typedef struct packed {
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] pc;
    } instr_t;

    typedef struct packed {
        logic        v;
        logic        we;
        logic        mr;
        logic        mw;
        logic        br;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] val;
        logic [31:0] sd;
        logic [31:0] tgt;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic [4:0]  rd_s;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        stall;
    logic        wb_we;
    logic [4:0]  wb_rd_s;
    logic [31:0] wb_rd_v;
    logic [31:0] ld_data;
    logic        res_valid;
    logic        res_we;
    logic [4:0]  res_rd_s;
    logic [31:0] res_value;
    logic [31:0] res_store_data;
    logic        res_mem_read;
    logic        res_mem_write;
    logic [2:0]  res_funct3;
    logic        br_en;
    logic [31:0] redirect_pc;

    // rf follows the dut results, arch_rf follows program order
    logic [31:0] rf [0:31];
    logic [31:0] arch_rf [0:31];
    instr_t      prog [$];
    opcode_t     op_list [0:8] = '{op_lui, op_auipc, op_imm, op_reg, op_load,
                                   op_store, op_br, op_jal, op_jalr};
    exp_t        cur = '0;
    exp_t        m_ex = '0;
    exp_t        m_res = '0;
    int          seed;
    int          stall_seed;
    int          stall_pct = 0;
    int          stall_left = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests = 0;
    int          failed = 0;
    logic [31:0] next_pc = 32'h0000_1000;
    logic        hung = 1'b0;

    clk_gen clocks
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_execute i_dut
    (
        .*
    );

    function automatic logic [31:0] load_word(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h5a5a, ~addr[31:16]};
    endfunction

    // data memory answers in the same cycle
    assign ld_data = load_word(res_value);

    function automatic exp_t reference_result(input instr_t i, input logic [31:0] a1,
                                              input logic [31:0] a2);
        exp_t        e;
        logic [31:0] b;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        e = '0;
        e.v = 1'b1;
        e.f3 = i.f3;
        e.rd = i.rd;
        e.sd = a2;
        e.we = !(i.op inside {op_br, op_store});
        b = (i.op == op_reg) ? a2 : i.imm;
        case (i.op)
            op_lui:   e.val = i.imm;
            op_auipc: e.val = i.pc + i.imm;
            op_jal, op_jalr:
            begin
                e.val = i.pc + 32'd4;
                e.br = 1'b1;
                e.tgt = (i.op == op_jal) ? i.pc + i.imm : (a1 + i.imm) & ~32'd1;
            end
            op_br:
            begin
                e.tgt = i.pc + i.imm;
                case (i.f3)
                    3'b000:  e.br = (a1 == a2);
                    3'b001:  e.br = (a1 != a2);
                    3'b100:  e.br = ($signed(a1) < $signed(a2));
                    3'b101:  e.br = ($signed(a1) >= $signed(a2));
                    3'b110:  e.br = (a1 < a2);
                    default: e.br = (a1 >= a2);
                endcase
            end
            op_load:
            begin
                e.val = a1 + i.imm;
                e.mr = 1'b1;
            end
            op_store:
            begin
                e.val = a1 + i.imm;
                e.mw = 1'b1;
            end
            default:
            begin
                if (i.op == op_reg && i.f7 == funct7_mul)
                begin
                    ea = (i.f3[1:0] inside {2'b01, 2'b10}) ? {{32{a1[31]}}, a1} : {32'h0, a1};
                    eb = (i.f3[1:0] == 2'b01) ? {{32{a2[31]}}, a2} : {32'h0, a2};
                    prod = ea * eb;
                    e.val = (i.f3[1:0] == 2'b00) ? prod[31:0] : prod[63:32];
                end
                else
                begin
                    case (i.f3)
                        3'b000:  e.val = (i.op == op_reg && i.f7[5]) ? a1 - b : a1 + b;
                        3'b001:  e.val = a1 << b[4:0];
                        3'b010:  e.val = {31'd0, $signed(a1) < $signed(b)};
                        3'b011:  e.val = {31'd0, a1 < b};
                        3'b100:  e.val = a1 ^ b;
                        3'b110:  e.val = a1 | b;
                        3'b111:  e.val = a1 & b;
                        default:
                        begin
                            if (i.f7[5])
                                e.val = $signed(a1) >>> b[4:0];
                            else
                                e.val = a1 >> b[4:0];
                        end
                    endcase
                end
            end
        endcase
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic queue_instrs(input int mix, input int span, input int count);
        instr_t      i;
        int unsigned r;
        int unsigned base;
        int unsigned width;
        base = (mix == 2) ? 2 : 0;
        case (mix)
            0:       width = 4;
            1:       width = 6;
            2:       width = 7;
            default: width = 9;
        endcase
        repeat (count)
        begin
            r = $random(seed);
            i = '0;
            i.op = op_list[base + (r[31:28] % width)];
            i.f3 = r[10:8];
            i.rs1 = r[15:11] % span;
            i.rs2 = r[20:16] % span;
            i.rd = r[25:21] % span;
            i.imm = $random(seed);
            i.pc = next_pc;
            next_pc = next_pc + 32'd4;
            case (i.op)
                op_lui, op_auipc: i.imm[11:0] = 12'h000;
                op_br:
                begin
                    if (i.f3[2:1] == 2'b01)
                        i.f3[1] = 1'b0;
                    i.imm[0] = 1'b0;
                end
                op_imm:
                begin
                    if (i.f3 == 3'b001)
                        i.imm[11:5] = 7'h00;
                    if (i.f3 == 3'b101)
                        i.imm[11:5] = r[26] ? 7'h20 : 7'h00;
                    i.f7 = i.imm[11:5];
                end
                op_reg:
                begin
                    if (r[27])
                    begin
                        i.f7 = funct7_mul;
                        i.f3[2] = 1'b0;
                    end
                    else if (r[26] && (i.f3 == 3'b000 || i.f3 == 3'b101))
                        i.f7 = 7'h20;
                end
                default: ;
            endcase
            prog.push_back(i);
        end
    endtask

    // the instruction at the inputs is squashed when the one entering ex redirects
    task automatic issue_next;
        instr_t i;
        logic   squashed;
        squashed = cur.v && cur.br;
        if (prog.size() > 0)
        begin
            i = prog.pop_front();
            cur = reference_result(i, arch_rf[i.rs1], arch_rf[i.rs2]);
            if (squashed)
                cur = '0;
            else if (cur.we && i.rd != 5'd0)
                arch_rf[i.rd] = cur.mr ? load_word(cur.val) : cur.val;
            issue_valid <= 1'b1;
            opcode <= opcode_t'(i.op);
            funct3 <= i.f3;
            funct7 <= i.f7;
            rs1_s <= i.rs1;
            rs2_s <= i.rs2;
            rd_s <= i.rd;
            rs1_v <= rf[i.rs1];
            rs2_v <= rf[i.rs2];
            imm <= i.imm;
            pc <= i.pc;
        end
        else
        begin
            cur = '0;
            issue_valid <= 1'b0;
        end
    endtask

    // surrounding stages: write-back, register file and issue
    always @(posedge clk)
    begin
        if (rst_n && !stall)
        begin
            wb_we <= res_valid && res_we;
            wb_rd_s <= res_rd_s;
            wb_rd_v <= res_mem_read ? ld_data : res_value;
            if (res_valid && res_we && res_rd_s != 5'd0)
                rf[res_rd_s] = res_mem_read ? ld_data : res_value;
            m_res <= m_ex;
            m_ex <= cur;
            issue_next();
        end
        if (rst_n)
        begin
            if (stall_left > 0)
            begin
                stall <= 1'b1;
                stall_left--;
            end
            else if (stall_pct > 0 && ($unsigned($random(stall_seed)) % 100) < stall_pct)
            begin
                stall <= 1'b1;
                stall_left = $unsigned($random(stall_seed)) % 4;
            end
            else
                stall <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            check_val("br_en", br_en, !stall && m_ex.v && m_ex.br);
            if (!stall && m_ex.v && m_ex.br)
                check_val("redirect_pc", redirect_pc, m_ex.tgt);
            check_val("res_valid", res_valid, m_res.v);
            if (m_res.v)
            begin
                check_val("res_we", res_we, m_res.we);
                check_val("res_rd_s", res_rd_s, m_res.rd);
                check_val("res_funct3", res_funct3, m_res.f3);
                check_val("res_mem_read", res_mem_read, m_res.mr);
                check_val("res_mem_write", res_mem_write, m_res.mw);
                if (m_res.we || m_res.mr || m_res.mw)
                    check_val("res_value", res_value, m_res.val);
                if (m_res.mw)
                    check_val("res_store_data", res_store_data, m_res.sd);
            end
        end
    end

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        while (!hung && (prog.size() > 0 || cur.v || m_ex.v || m_res.v))
        begin
            @(negedge clk);
            cnt++;
            if (cnt > 5000)
            begin
                $display("timeout: pipeline did not drain during %s", what);
                hung = 1'b1;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark && !hung)
            $display("test %s passed", name);
        else
        begin
            $display("test %s failed with %0d mismatches", name, errors - err_mark);
            failed++;
        end
        err_mark = errors;
    endtask

    initial
    begin
        int cnt;
        seed = 32'hf6d3_5444;
        stall_seed = seed ^ 32'h0000_ffff;
        issue_valid = 1'b0;
        opcode = op_imm;
        funct3 = '0;
        funct7 = '0;
        rs1_s = '0;
        rs2_s = '0;
        rd_s = '0;
        rs1_v = '0;
        rs2_v = '0;
        imm = '0;
        pc = '0;
        stall = 1'b0;
        wb_we = 1'b0;
        wb_rd_s = '0;
        wb_rd_v = '0;
        for (int k = 0; k < 32; k++)
        begin
            rf[k] = (k == 0) ? 32'd0 : $random(seed);
            arch_rf[k] = rf[k];
        end

        cnt = 0;
        while (rst_n !== 1'b1 && !hung)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > 100)
            begin
                $display("timeout: reset never released");
                hung = 1'b1;
            end
        end
        @(posedge clk);
        check_val("res_valid", res_valid, 1'b0);
        check_val("res_we", res_we, 1'b0);
        check_val("res_mem_read", res_mem_read, 1'b0);
        check_val("res_mem_write", res_mem_write, 1'b0);
        check_val("br_en", br_en, 1'b0);
        finish_test("reset state");

        @(negedge clk);
        queue_instrs(0, 32, 300);
        wait_idle("random alu and multiply");
        finish_test("random alu and multiply");

        // few registers, so most instructions depend on the one before
        @(negedge clk);
        queue_instrs(1, 4, 300);
        wait_idle("dependent sequence");
        finish_test("dependent sequence");

        @(negedge clk);
        queue_instrs(2, 8, 300);
        wait_idle("branches and jumps");
        finish_test("branches and jumps");

        @(negedge clk);
        stall_pct = 30;
        queue_instrs(3, 4, 300);
        wait_idle("random stalls");
        stall_pct = 0;
        wait_idle("stall release");
        finish_test("random stalls");

        $display("%0d tests, %0d failed, %0d mismatches", tests, failed, errors);
        if (errors == 0 && !hung)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: rv32_execute.f
rtl/rv32i_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/id_ex_latch.sv
rtl/forwarding_unit.sv
rtl/pipeline_alu.sv
rtl/mul_unit.sv
rtl/ex_stage.sv
rtl/ex_mem_latch.sv
rtl/rv32_execute.sv
bench/clk_gen.sv
bench/tb_rv32_execute.sv
